// ==== verilog.f ====
spi_pkg.sv
spi_fifo.sv
spi_clkgen.sv
spi_sequencer.sv
spi_controller.sv
spi_controller_properties.sv
tb_spi_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_spi_controller
FILELIST  ?= verilog.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "=== PASS ==="

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== tb_spi_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_controller;

  localparam int unsigned DW = 32;
  localparam int unsigned DEPTH = 16;
  localparam int TIMEOUT = 20000;

  logic clk_i, rst_ni, cfg_cpol_i, trigger_tx_i, trigger_rx_i, sw_rst_i;
  logic tx_push_i, rx_pop_i, spi_miso_i, op_done_o, rx_valid_o, spi_clk_o, spi_mosi_o;
  logic [7:0] cfg_clkdiv_i;
  logic [31:0] cfg_cmd_i, cfg_addr_i, cfg_len_i, cfg_dummy_i;
  logic [1:0] cfg_cs_idx_i;
  logic [DW-1:0] tx_data_i, rx_data_o;
  logic [$clog2(DEPTH):0] tx_elements_o, rx_elements_o;
  logic [3:0] spi_csn_o;

  // Slave model records, one entry per pad rising edge
  logic mosi_q[$];
  logic miso_q[$];
  logic [3:0] csn_q[$];
  int gap_q[$];
  logic exp_q[$];
  logic [DW-1:0] words_q[$];
  logic pad_q;
  int cyc, last_rise, seed, errors, tests, failed, err_mark;

  spi_controller #(.DATA_WIDTH(DW), .FIFO_DEPTH(DEPTH)) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Values read here are the ones before the edge, so a rise shows one cycle late
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    pad_q <= spi_clk_o;
    if (!pad_q && spi_clk_o && spi_csn_o != 4'hf) begin
      mosi_q.push_back(spi_mosi_o);
      miso_q.push_back(spi_miso_i);
      csn_q.push_back(spi_csn_o);
      if (last_rise >= 0) gap_q.push_back(cyc - last_rise);
      last_rise <= cyc;
    end
    if (spi_csn_o == 4'hf) last_rise <= -1;
    // New MISO bit after each falling edge
    if (pad_q && !spi_clk_o) spi_miso_i <= 1'($random(seed));
  end

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("Error at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (op_done_o !== 1'b1) begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT) begin
        $display("Timed out waiting for the end of a transfer");
        $display("=== FAIL ===");
        $finish;
      end
    end
    @(posedge clk_i);
  endtask

  task automatic wait_rx_count(input int cnt);
    int n;
    n = 0;
    while (rx_elements_o != cnt) begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT) begin
        $display("Timed out waiting for the receive FIFO to fill");
        $display("=== FAIL ===");
        $finish;
      end
    end
  endtask

  task automatic push_words(input int cnt);
    logic [DW-1:0] w;
    for (int i = 0; i < cnt; i++) begin
      w = $random(seed);
      if (words_q.size() < DEPTH) words_q.push_back(w);
      @(posedge clk_i);
      tx_push_i <= 1'b1;
      tx_data_i <= w;
    end
    @(posedge clk_i);
    tx_push_i <= 1'b0;
    @(posedge clk_i);
  endtask

  // Header fields then data words MSB first, zeros once the stored words run out
  task automatic build_expected();
    int dlen;
    exp_q.delete();
    for (int i = cfg_len_i[7:0] - 1; i >= 0; i--) exp_q.push_back(cfg_cmd_i[i]);
    for (int i = cfg_len_i[15:8] - 1; i >= 0; i--) exp_q.push_back(cfg_addr_i[i]);
    for (int i = 0; i < cfg_dummy_i; i++) exp_q.push_back(1'b0);
    dlen = cfg_len_i[31:16];
    for (int i = 0; i < dlen; i++) begin
      if (i / DW < words_q.size()) exp_q.push_back(words_q[i / DW][DW - 1 - i % DW]);
      else exp_q.push_back(1'b0);
    end
  endtask

  task automatic run_transfer(input logic tx);
    mosi_q.delete();
    miso_q.delete();
    csn_q.delete();
    gap_q.delete();
    @(posedge clk_i);
    if (tx) trigger_tx_i <= 1'b1;
    else trigger_rx_i <= 1'b1;
    @(posedge clk_i);
    trigger_tx_i <= 1'b0;
    trigger_rx_i <= 1'b0;
    wait_done();
  endtask

  task automatic check_tx_stream();
    build_expected();
    check(mosi_q.size() == exp_q.size(), "MOSI bit count differs");
    foreach (mosi_q[i]) begin
      if (i < exp_q.size() && mosi_q[i] !== exp_q[i]) begin
        check(1'b0, $sformatf("MOSI bit %0d wrong", i));
        break;
      end
    end
    foreach (csn_q[i]) check(csn_q[i] == ~(4'b1 << cfg_cs_idx_i), "wrong chip select");
    check(tx_elements_o == 0, "TX FIFO not drained");
  endtask

  task automatic report(input string name);
    tests++;
    if (errors != err_mark) failed++;
    $display("%s: %s", name, (errors != err_mark) ? "failed" : "ok");
    err_mark = errors;
  endtask

  task automatic setup_tx();
    cfg_cmd_i <= 32'h9f;
    cfg_addr_i <= 32'hbeef;
    cfg_dummy_i <= 32'd4;
    cfg_len_i <= {16'd64, 8'd16, 8'd8};
    cfg_cs_idx_i <= 2'd2;
    words_q.delete();
    push_words(2);
  endtask

  initial begin
    logic [DW-1:0] w;
    seed = 8;
    cyc = 0;
    last_rise = -1;
    errors = 0;
    tests = 0;
    failed = 0;
    err_mark = 0;
    rst_ni = 1'b0;
    cfg_clkdiv_i = 8'd1;
    cfg_cpol_i = 1'b0;
    cfg_cmd_i = '0;
    cfg_addr_i = '0;
    cfg_len_i = '0;
    cfg_dummy_i = '0;
    cfg_cs_idx_i = '0;
    trigger_tx_i = 1'b0;
    trigger_rx_i = 1'b0;
    sw_rst_i = 1'b0;
    tx_push_i = 1'b0;
    tx_data_i = '0;
    rx_pop_i = 1'b0;
    spi_miso_i = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    setup_tx();
    run_transfer(1'b1);
    check_tx_stream();
    report("mode 0 transmit");

    // 8 command bits then 40 received bits
    cfg_len_i <= {16'd40, 8'd0, 8'd8};
    cfg_dummy_i <= '0;
    run_transfer(1'b0);
    wait_rx_count(2);
    check(rx_valid_o, "RX data not flagged valid");
    for (int i = 0; i < 32; i++) w[31 - i] = miso_q[8 + i];
    check(rx_data_o == w, "first received word wrong");
    @(posedge clk_i);
    rx_pop_i <= 1'b1;
    @(posedge clk_i);
    rx_pop_i <= 1'b0;
    @(posedge clk_i);
    w = '0;
    for (int i = 0; i < 8; i++) w[7 - i] = miso_q[40 + i];
    check(rx_data_o == w, "partial received word wrong");
    rx_pop_i <= 1'b1;
    @(posedge clk_i);
    rx_pop_i <= 1'b0;
    @(posedge clk_i);
    check(rx_elements_o == 0 && !rx_valid_o, "RX FIFO not empty after pops");
    report("receive with partial word");

    cfg_cpol_i <= 1'b1;
    setup_tx();
    run_transfer(1'b1);
    check_tx_stream();
    check(spi_clk_o == 1'b1, "clock not idle high in mode 3");
    report("mode 3 transmit");
    cfg_cpol_i <= 1'b0;

    cfg_clkdiv_i <= 8'd3;
    setup_tx();
    run_transfer(1'b1);
    check(gap_q.size() > 0, "no clock edges seen");
    foreach (gap_q[i]) check(gap_q[i] == 8, "rising edge interval not 8 cycles");
    report("divider");
    cfg_clkdiv_i <= 8'd1;

    // Abort a receive transfer once its first word is stored
    words_q.delete();
    push_words(3);
    cfg_len_i <= {16'd64, 8'd0, 8'd8};
    cfg_dummy_i <= '0;
    @(posedge clk_i);
    trigger_rx_i <= 1'b1;
    @(posedge clk_i);
    trigger_rx_i <= 1'b0;
    wait_rx_count(1);
    check(spi_csn_o != 4'hf && tx_elements_o == 3, "transfer not running before reset");
    sw_rst_i <= 1'b1;
    @(posedge clk_i);
    sw_rst_i <= 1'b0;
    @(posedge clk_i);
    check(tx_elements_o == 0 && rx_elements_o == 0, "counts not cleared by reset");
    check(spi_csn_o == 4'hf, "chip select low after reset");
    setup_tx();
    run_transfer(1'b1);
    check_tx_stream();
    report("software reset");

    words_q.delete();
    push_words(17);
    check(tx_elements_o == DEPTH, "TX count not held at depth");
    cfg_len_i <= {16'd576, 8'd0, 8'd8};
    cfg_dummy_i <= '0;
    run_transfer(1'b1);
    check_tx_stream();
    report("full FIFO and zero fill");

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== spi_controller_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_controller_properties #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         cfg_cpol_i,
  input logic                         op_done_o,
  input logic                         spi_clk_o,
  input logic [spi_pkg::CS_NUM-1:0]   spi_csn_o,
  input logic [$clog2(FIFO_DEPTH):0]  tx_elements_o,
  input logic [$clog2(FIFO_DEPTH):0]  rx_elements_o
);

  // One slave at a time
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(~spi_csn_o))
    else $error("more than one chip select low");

  // Pad clock rests at the polarity level between transfers
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&spi_csn_o) |-> (spi_clk_o == cfg_cpol_i))
    else $error("spi clock not idle while deselected");

  // Done is a single-cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni) op_done_o |=> !op_done_o)
    else $error("done held for two cycles");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tx_elements_o <= FIFO_DEPTH) && (rx_elements_o <= FIFO_DEPTH))
    else $error("element count above depth");

endmodule

bind spi_controller spi_controller_properties #(
  .FIFO_DEPTH(FIFO_DEPTH)
) u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .cfg_cpol_i   (cfg_cpol_i),
  .op_done_o    (op_done_o),
  .spi_clk_o    (spi_clk_o),
  .spi_csn_o    (spi_csn_o),
  .tx_elements_o(tx_elements_o),
  .rx_elements_o(rx_elements_o)
);

`default_nettype wire

// ==== spi_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_controller #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [spi_pkg::CLKDIV_W-1:0] cfg_clkdiv_i,
  input  logic                         cfg_cpol_i,
  input  logic [spi_pkg::CFG_W-1:0]    cfg_cmd_i,
  input  logic [spi_pkg::CFG_W-1:0]    cfg_addr_i,
  input  logic [spi_pkg::CFG_W-1:0]    cfg_len_i,
  input  logic [spi_pkg::CFG_W-1:0]    cfg_dummy_i,
  input  logic [spi_pkg::CS_IDX_W-1:0] cfg_cs_idx_i,
  input  logic                         trigger_tx_i,
  input  logic                         trigger_rx_i,
  input  logic                         sw_rst_i,
  output logic                         op_done_o,
  input  logic                         tx_push_i,
  input  logic [DATA_WIDTH-1:0]        tx_data_i,
  input  logic                         rx_pop_i,
  output logic [DATA_WIDTH-1:0]        rx_data_o,
  output logic                         rx_valid_o,
  output logic [$clog2(FIFO_DEPTH):0]  tx_elements_o,
  output logic [$clog2(FIFO_DEPTH):0]  rx_elements_o,
  output logic                         spi_clk_o,
  output logic [spi_pkg::CS_NUM-1:0]   spi_csn_o,
  output logic                         spi_mosi_o,
  input  logic                         spi_miso_i
);

  // TX FIFO to sequencer
  logic                  tx_pop;
  logic                  tx_empty;
  logic [DATA_WIDTH-1:0] tx_head;
  // Sequencer to RX FIFO
  logic                  rx_push;
  logic [DATA_WIDTH-1:0] rx_word;
  logic                  rx_empty;
  // Clock generator handshake
  logic                  run;
  logic                  sample;
  logic                  shift;

  // Software reset empties both queues
  spi_fifo #(
    .payload_t (logic [DATA_WIDTH-1:0]),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_tx_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clr_i     (sw_rst_i),
    .push_i    (tx_push_i),
    .wr_data_i (tx_data_i),
    .pop_i     (tx_pop),
    .rd_data_o (tx_head),
    .empty_o   (tx_empty),
    .full_o    (),
    .elements_o(tx_elements_o)
  );

  spi_fifo #(
    .payload_t (logic [DATA_WIDTH-1:0]),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_rx_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clr_i     (sw_rst_i),
    .push_i    (rx_push),
    .wr_data_i (rx_word),
    .pop_i     (rx_pop_i),
    .rd_data_o (rx_data_o),
    .empty_o   (rx_empty),
    .full_o    (),
    .elements_o(rx_elements_o)
  );

  assign rx_valid_o = !rx_empty;

  spi_clkgen u_clkgen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .run_i       (run),
    .cfg_clkdiv_i(cfg_clkdiv_i),
    .cfg_cpol_i  (cfg_cpol_i),
    .spi_clk_o   (spi_clk_o),
    .sample_o    (sample),
    .shift_o     (shift)
  );

  spi_sequencer #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_seq (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sw_rst_i    (sw_rst_i),
    .trigger_tx_i(trigger_tx_i),
    .trigger_rx_i(trigger_rx_i),
    .cfg_cmd_i   (cfg_cmd_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_len_i   (cfg_len_i),
    .cfg_dummy_i (cfg_dummy_i),
    .cfg_cs_idx_i(cfg_cs_idx_i),
    .cfg_cpol_i  (cfg_cpol_i),
    .sample_i    (sample),
    .shift_i     (shift),
    .tx_data_i   (tx_head),
    .tx_empty_i  (tx_empty),
    .spi_miso_i  (spi_miso_i),
    .run_o       (run),
    .tx_pop_o    (tx_pop),
    .rx_push_o   (rx_push),
    .rx_data_o   (rx_word),
    .op_done_o   (op_done_o),
    .spi_csn_o   (spi_csn_o),
    .spi_mosi_o  (spi_mosi_o)
  );

endmodule

`default_nettype wire

// ==== spi_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_sequencer #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         sw_rst_i,
  input  logic                         trigger_tx_i,
  input  logic                         trigger_rx_i,
  input  logic [spi_pkg::CFG_W-1:0]    cfg_cmd_i,
  input  logic [spi_pkg::CFG_W-1:0]    cfg_addr_i,
  input  logic [spi_pkg::CFG_W-1:0]    cfg_len_i,
  input  logic [spi_pkg::CFG_W-1:0]    cfg_dummy_i,
  input  logic [spi_pkg::CS_IDX_W-1:0] cfg_cs_idx_i,
  input  logic                         cfg_cpol_i,
  input  logic                         sample_i,
  input  logic                         shift_i,
  input  logic [DATA_WIDTH-1:0]        tx_data_i,
  input  logic                         tx_empty_i,
  input  logic                         spi_miso_i,
  output logic                         run_o,
  output logic                         tx_pop_o,
  output logic                         rx_push_o,
  output logic [DATA_WIDTH-1:0]        rx_data_o,
  output logic                         op_done_o,
  output logic [spi_pkg::CS_NUM-1:0]   spi_csn_o,
  output logic                         spi_mosi_o
);

  import spi_pkg::*;

  localparam int unsigned WCNT_W = $clog2(DATA_WIDTH) + 1;
  localparam int unsigned IDX_W  = $clog2(CFG_W);

  spi_phase_e state_q;
  spi_phase_e state_d;
  spi_phase_e data_ph;
  spi_phase_e after_dummy;
  spi_phase_e after_addr;
  spi_phase_e after_cmd;
  spi_phase_e start_ph;
  spi_phase_e phase_next;

  logic [CMD_LEN_W-1:0]  cmd_len;
  logic [ADDR_LEN_W-1:0] addr_len;
  logic [DATA_LEN_W-1:0] data_len;
  logic [CFG_W-1:0]      bit_cnt_q;
  logic [CFG_W-1:0]      bit_cnt_d;
  logic [CFG_W-1:0]      next_len;
  logic [CFG_W-1:0]      bit_idx;
  logic [WCNT_W-1:0]     word_cnt_q;
  logic [WCNT_W-1:0]     word_cnt_d;
  logic [DATA_WIDTH-1:0] shift_q;
  logic [DATA_WIDTH-1:0] shift_d;
  logic [DATA_WIDTH-1:0] rx_next;
  logic                  dir_tx_q;
  logic                  dir_tx_now;
  logic                  first_q;
  logic                  op_done_q;
  logic                  mosi_last_q;
  logic                  active;
  logic                  shift_eff;
  logic                  end_strobe;
  logic                  final_bit;
  logic                  adv;
  logic                  tx_load;

  assign cmd_len  = cfg_len_i[CMD_LEN_W-1:0];
  assign addr_len = cfg_len_i[CMD_LEN_W +: ADDR_LEN_W];
  assign data_len = cfg_len_i[CMD_LEN_W+ADDR_LEN_W +: DATA_LEN_W];

  // Direction follows the trigger while idle and is held afterwards
  assign dir_tx_now = (state_q == IDLE) ? trigger_tx_i : dir_tx_q;
  assign data_ph    = dir_tx_now ? DATA_TX : DATA_RX;

  // Phase chain, zero-length phases fall through
  assign after_dummy = (data_len != '0) ? data_ph : LAST;
  assign after_addr  = (cfg_dummy_i != '0) ? DUMMY : after_dummy;
  assign after_cmd   = (addr_len != '0) ? ADDR : after_addr;
  assign start_ph    = (cmd_len != '0) ? CMD : after_cmd;

  always_comb begin
    case (state_q)
      CMD:     phase_next = after_cmd;
      ADDR:    phase_next = after_addr;
      DUMMY:   phase_next = after_dummy;
      default: phase_next = LAST;
    endcase
  end

  // Bit count of the phase being entered
  always_comb begin
    case (state_d)
      CMD:              next_len = CFG_W'(cmd_len);
      ADDR:             next_len = CFG_W'(addr_len);
      DUMMY:            next_len = cfg_dummy_i;
      DATA_TX, DATA_RX: next_len = CFG_W'(data_len);
      default:          next_len = '0;
    endcase
  end

  assign active = (state_q inside {CMD, ADDR, DUMMY, DATA_TX, DATA_RX});
  // Software reset stops the clock in the same cycle as the abort
  assign run_o  = active && !sw_rst_i;

  // Mode 3 leading edge carries no new bit
  assign shift_eff = shift_i && (!cfg_cpol_i || first_q);
  // Transfer ends on the edge that returns the pad to idle
  assign end_strobe = cfg_cpol_i ? sample_i : shift_i;
  assign final_bit  = (bit_cnt_q == CFG_W'(1)) && (phase_next == LAST);
  assign adv        = active && (final_bit ? end_strobe : shift_eff);

  // Receive bits enter at the LSB, so a partial word ends right-aligned
  assign rx_next   = {shift_q[DATA_WIDTH-2:0], spi_miso_i};
  assign rx_data_o = rx_next;
  assign bit_idx   = bit_cnt_q - 1'b1;

  always_comb begin
    state_d    = state_q;
    bit_cnt_d  = bit_cnt_q;
    word_cnt_d = word_cnt_q;
    shift_d    = shift_q;
    tx_load    = 1'b0;
    tx_pop_o   = 1'b0;
    rx_push_o  = 1'b0;

    case (state_q)
      IDLE: begin
        if (trigger_tx_i || trigger_rx_i) begin
          state_d = start_ph;
        end
      end
      CMD, ADDR, DUMMY, DATA_TX, DATA_RX: begin
        if (adv) begin
          if (bit_cnt_q == CFG_W'(1)) begin
            state_d = phase_next;
          end else begin
            bit_cnt_d = bit_cnt_q - 1'b1;
            // Word boundary refills from the TX FIFO
            if (state_q == DATA_TX) begin
              if (word_cnt_q == WCNT_W'(1)) begin
                tx_load = 1'b1;
              end else begin
                shift_d    = {shift_q[DATA_WIDTH-2:0], 1'b0};
                word_cnt_d = word_cnt_q - 1'b1;
              end
            end
          end
        end
      end
      LAST:    state_d = FINISH;
      FINISH:  state_d = IDLE;
      default: state_d = IDLE;
    endcase

    // Push on a full word or on the last bit of the data phase
    if (state_q == DATA_RX && sample_i) begin
      if (word_cnt_q == WCNT_W'(DATA_WIDTH - 1) || bit_cnt_q == CFG_W'(1)) begin
        rx_push_o  = 1'b1;
        shift_d    = '0;
        word_cnt_d = '0;
      end else begin
        shift_d    = rx_next;
        word_cnt_d = word_cnt_q + 1'b1;
      end
    end

    // Phase entry loads the new bit count
    if (state_d != state_q) begin
      bit_cnt_d = next_len;
      if (state_d == DATA_TX) begin
        tx_load = 1'b1;
      end else if (state_d == DATA_RX) begin
        shift_d    = '0;
        word_cnt_d = '0;
      end
    end

    // Empty FIFO gives a word of zeros
    if (tx_load) begin
      tx_pop_o   = !tx_empty_i;
      shift_d    = tx_empty_i ? '0 : tx_data_i;
      word_cnt_d = WCNT_W'(DATA_WIDTH);
    end
  end

  always_comb begin
    case (state_q)
      CMD:     spi_mosi_o = cfg_cmd_i[bit_idx[IDX_W-1:0]];
      ADDR:    spi_mosi_o = cfg_addr_i[bit_idx[IDX_W-1:0]];
      DATA_TX: spi_mosi_o = shift_q[DATA_WIDTH-1];
      // Mode 3 samples the last bit on the edge into LAST, so it stays on the line
      LAST:    spi_mosi_o = mosi_last_q;
      // Dummy and receive phases hold MOSI low
      default: spi_mosi_o = 1'b0;
    endcase
  end

  // Selected line is low from the first phase through LAST
  always_comb begin
    spi_csn_o = '1;
    if (active || state_q == LAST) begin
      spi_csn_o[cfg_cs_idx_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      bit_cnt_q   <= '0;
      word_cnt_q  <= '0;
      dir_tx_q    <= 1'b0;
      first_q     <= 1'b0;
      op_done_q   <= 1'b0;
      mosi_last_q <= 1'b0;
    end else if (sw_rst_i) begin
      state_q   <= IDLE;
      first_q   <= 1'b0;
      op_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      bit_cnt_q   <= bit_cnt_d;
      word_cnt_q  <= word_cnt_d;
      dir_tx_q    <= dir_tx_now;
      // Set by the first shift edge, cleared once the clock stops
      first_q     <= active && (first_q || shift_i);
      op_done_q   <= (state_q == FINISH);
      mosi_last_q <= spi_mosi_o;
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q <= shift_d;
  end

  assign op_done_o = op_done_q;

endmodule

`default_nettype wire

// ==== spi_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_clkgen (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         run_i,
  input  logic [spi_pkg::CLKDIV_W-1:0] cfg_clkdiv_i,
  input  logic                         cfg_cpol_i,
  output logic                         spi_clk_o,
  output logic                         sample_o,
  output logic                         shift_o
);

  // Half-period counter
  logic [spi_pkg::CLKDIV_W-1:0] cnt_q;
  // Internal clock, starts low at every transfer
  logic                         clk_q;
  // Last count of a half period, the internal clock toggles next cycle
  logic                         tick;

  assign tick = run_i && (cnt_q == cfg_clkdiv_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      clk_q <= 1'b0;
    end else if (!run_i) begin
      // Stopped, pad rests at the idle level
      cnt_q <= '0;
      clk_q <= 1'b0;
    end else if (tick) begin
      cnt_q <= '0;
      clk_q <= ~clk_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Pad level, inverted for CPOL=1 so it idles high
  assign spi_clk_o = clk_q ^ cfg_cpol_i;

  // Strobes lead the pad edge by one system cycle
  // CPOL=0: internal rise is pad rise, so sample there
  // CPOL=1: internal fall is pad rise, strobes swap
  assign sample_o = tick && (clk_q == cfg_cpol_i);
  assign shift_o  = tick && (clk_q != cfg_cpol_i);

endmodule

`default_nettype wire

// ==== spi_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_fifo #(
  parameter type         payload_t  = logic [31:0],
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clr_i,
  input  logic                        push_i,
  input  payload_t                    wr_data_i,
  input  logic                        pop_i,
  output payload_t                    rd_data_o,
  output logic                        empty_o,
  output logic                        full_o,
  output logic [$clog2(FIFO_DEPTH):0] elements_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  // Storage, written only on an accepted push
  payload_t mem_q [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == (PTR_W + 1)'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);

  // Push while full and pop while empty are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap on their own since depth is a power of two
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count unchanged
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  // Head of queue, valid whenever not empty
  assign rd_data_o  = mem_q[rd_ptr_q];
  assign elements_o = count_q;

endmodule

`default_nettype wire

// ==== spi_pkg.sv ====
`default_nettype none

package spi_pkg;

  // Chip-select lines and the width of their index
  localparam int unsigned CS_NUM   = 4;
  localparam int unsigned CS_IDX_W = 2;

  // Bit-count fields packed into cfg_len_i
  // Command in [7:0], address in [15:8], data in [31:16]
  localparam int unsigned CMD_LEN_W  = 8;
  localparam int unsigned ADDR_LEN_W = 8;
  localparam int unsigned DATA_LEN_W = 16;

  // Command, address, length and dummy words
  localparam int unsigned CFG_W = 32;

  // Divider setting, half period is value plus one system cycles
  localparam int unsigned CLKDIV_W = 8;

  // Transfer phases of the sequencer
  typedef enum logic [3:0] {
    IDLE,
    CMD,
    ADDR,
    DUMMY,
    DATA_TX,
    DATA_RX,
    // Clock stopped, chip select still low
    LAST,
    // Chip select released
    FINISH
  } spi_phase_e;

endpackage

`default_nettype wire
